//--- design/rv_decode_params.svh
// widths and fixed register indices for the decode stage, included by the package and RTL
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// datapath width, rv64
`define RV_XLEN 64

// base instruction width
// no compressed support here
`define RV_ILEN 32

// register file index width
`define RV_REG_W 5

// ecall results land in a0
// the fake os layer reads them back from there
`define RV_REG_A0 10

// hardwired zero register
// used to null rs1 for lui, auipc and jal
`define RV_REG_ZERO 0

`endif

//--- design/rv_decode_pkg.sv
// shared enums and record types for the decode stage, imported by every decode module
`include "rv_decode_params.svh"

package rv_decode_pkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_LUI      = 7'b0110111,
        OP_AUIPC    = 7'b0010111,
        OP_JAL      = 7'b1101111,
        OP_JALR     = 7'b1100111,
        OP_BRANCH   = 7'b1100011,
        OP_LOAD     = 7'b0000011,
        OP_STORE    = 7'b0100011,
        OP_OP_IMM   = 7'b0010011,
        OP_IMM_32   = 7'b0011011,
        OP_OP       = 7'b0110011,
        OP_OP_32    = 7'b0111011,
        OP_MISC_MEM = 7'b0001111,
        OP_SYSTEM   = 7'b1110011
    } opcode_e;

    // alu funct3 codes
    // srx covers both srl and sra, funct7 picks
    typedef enum logic [2:0] {
        F3OP_ADD_SUB = 3'b000,
        F3OP_SLL     = 3'b001,
        F3OP_SLT     = 3'b010,
        F3OP_SLTU    = 3'b011,
        F3OP_XOR     = 3'b100,
        F3OP_SRX     = 3'b101,
        F3OP_OR      = 3'b110,
        F3OP_AND     = 3'b111
    } f3_op_e;

    // branch funct3 codes
    // 010 and 011 are reserved
    typedef enum logic [2:0] {
        F3B_BEQ  = 3'b000,
        F3B_BNE  = 3'b001,
        F3B_BLT  = 3'b100,
        F3B_BGE  = 3'b101,
        F3B_BLTU = 3'b110,
        F3B_BGEU = 3'b111
    } f3_branch_e;

    // when the exec stage takes the jump
    typedef enum logic [1:0] {
        JUMP_NO      = 2'd0,
        JUMP_YES     = 2'd1,
        JUMP_ALU_EQZ = 2'd2,
        JUMP_ALU_NEZ = 2'd3
    } jump_code_e;

    // immediate layout selected by the main decoder
    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_SB   = 3'd3,
        IMM_U    = 3'd4,
        IMM_UJ   = 3'd5
    } imm_fmt_e;

    // branch condition plus the alu op that evaluates it
    typedef struct packed {
        jump_code_e jump_if;
        f3_op_e     funct3;
        logic [6:0] funct7;
    } branch_ctrl_t;

    // full decoded instruction handed to exec
    typedef struct packed {
        // register indices, rs1 may be forced to x0
        logic [`RV_REG_W-1:0] rs1;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rd;
        // register use, for hazard detect and writeback
        logic                 en_rs1;
        logic                 en_rs2;
        logic                 en_rd;
        logic [`RV_XLEN-1:0]  immed;
        // auipc, exec adds pc to the alu result
        logic                 keep_pc_plus_immed;
        // alu operand b is immed instead of rs2
        logic                 alu_use_immed;
        // word ops, addw and friends
        logic                 alu_width_32;
        // possibly rewritten alu controls
        logic [2:0]           funct3;
        logic [6:0]           funct7;
        // jal and branches are pc relative, jalr absolute
        jump_code_e           jump_if;
        logic                 jump_absolute;
        logic                 is_load;
        logic                 is_store;
        logic                 is_ecall;
    } decoded_inst_t;

endpackage

//--- design/rv_branch_decode.sv
// branch decoder, turns a branch funct3 into a jump condition and the alu compare that drives it
`timescale 1ns/1ps

module rv_branch_decode (
    input  logic [2:0]                  funct3,
    output rv_decode_pkg::branch_ctrl_t br
);

    import rv_decode_pkg::*;

    f3_branch_e code;

    assign code = f3_branch_e'(funct3);

    always_comb begin
        // reserved codes never jump
        br.jump_if = JUMP_NO;
        br.funct3  = F3OP_ADD_SUB;
        br.funct7  = 7'b000_0000;

        case (code)
            // rs1 - rs2, equal when the difference is zero
            F3B_BEQ: begin
                br.jump_if = JUMP_ALU_EQZ;
                br.funct7  = 7'b010_0000;
            end
            F3B_BNE: begin
                br.jump_if = JUMP_ALU_NEZ;
                br.funct7  = 7'b010_0000;
            end
            // slt gives 1 when less than
            F3B_BLT: begin
                br.jump_if = JUMP_ALU_NEZ;
                br.funct3  = F3OP_SLT;
            end
            // not less than means ge
            F3B_BGE: begin
                br.jump_if = JUMP_ALU_EQZ;
                br.funct3  = F3OP_SLT;
            end
            // unsigned variants
            F3B_BLTU: begin
                br.jump_if = JUMP_ALU_NEZ;
                br.funct3  = F3OP_SLTU;
            end
            F3B_BGEU: begin
                br.jump_if = JUMP_ALU_EQZ;
                br.funct3  = F3OP_SLTU;
            end
            default: begin
                br.jump_if = JUMP_NO;
            end
        endcase
    end

endmodule

//--- design/rv_imm_gen.sv
// immediate generator, builds every rv64 immediate layout and returns the one the decoder asks for
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_imm_gen (
    input  logic [`RV_ILEN-1:0]      inst,
    input  rv_decode_pkg::imm_fmt_e  fmt,
    output logic [`RV_XLEN-1:0]      immed
);

    import rv_decode_pkg::*;

    // sign bit is always inst[31]
    logic                sign;
    logic [`RV_XLEN-1:0] immed_i;
    logic [`RV_XLEN-1:0] immed_s;
    logic [`RV_XLEN-1:0] immed_sb;
    logic [`RV_XLEN-1:0] immed_u;
    logic [`RV_XLEN-1:0] immed_uj;

    assign sign = inst[31];

    // 12 bits straight from the top
    assign immed_i = {{(`RV_XLEN-12){sign}}, inst[31:20]};

    // 12 bits split around rd
    assign immed_s = {{(`RV_XLEN-12){sign}}, inst[31:25], inst[11:7]};

    // 13 bits, halfword aligned
    assign immed_sb = {{(`RV_XLEN-13){sign}}, inst[31], inst[7],
                       inst[30:25], inst[11:8], 1'b0};

    // upper 20, low 12 zero
    assign immed_u = {{(`RV_XLEN-32){sign}}, inst[31:12], 12'b0};

    // 21 bits, scrambled, halfword aligned
    assign immed_uj = {{(`RV_XLEN-21){sign}}, inst[31], inst[19:12],
                       inst[20], inst[30:21], 1'b0};

    // format select
    always_comb begin
        case (fmt)
            IMM_I:   immed = immed_i;
            IMM_S:   immed = immed_s;
            IMM_SB:  immed = immed_sb;
            IMM_U:   immed = immed_u;
            IMM_UJ:  immed = immed_uj;
            // no immediate, keep it quiet
            default: immed = '0;
        endcase
    end

endmodule

//--- design/rv_ctrl_decode.sv
// main opcode decoder, fills the decoded record (immediate left zero) and picks the immediate format
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_ctrl_decode (
    input  logic [`RV_ILEN-1:0]          inst,
    input  rv_decode_pkg::branch_ctrl_t  br,
    output rv_decode_pkg::imm_fmt_e      fmt,
    output rv_decode_pkg::decoded_inst_t ctrl
);

    import rv_decode_pkg::*;

    opcode_e    op;
    logic [2:0] f3;

    assign op = opcode_e'(inst[6:0]);
    assign f3 = inst[14:12];

    always_comb begin
        // raw fields, overridden per opcode
        ctrl.rs1    = inst[19:15];
        ctrl.rs2    = inst[24:20];
        ctrl.rd     = inst[11:7];
        ctrl.funct3 = f3;
        ctrl.funct7 = inst[31:25];

        // nothing enabled until an opcode claims it
        {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b000;
        ctrl.immed              = '0;
        ctrl.keep_pc_plus_immed = 1'b0;
        ctrl.alu_use_immed      = 1'b0;
        ctrl.alu_width_32       = 1'b0;
        ctrl.jump_if            = JUMP_NO;
        ctrl.jump_absolute      = 1'b0;
        ctrl.is_load            = 1'b0;
        ctrl.is_store           = 1'b0;
        ctrl.is_ecall           = 1'b0;
        fmt                     = IMM_NONE;

        case (op)
            // alu computes x0 + immed
            OP_LUI, OP_AUIPC: begin
                fmt                = IMM_U;
                ctrl.rs1           = `RV_REG_W'(`RV_REG_ZERO);
                ctrl.funct3        = F3OP_ADD_SUB;
                ctrl.funct7        = 7'b000_0000;
                ctrl.alu_use_immed = 1'b1;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b001;
                // separate adder tacks on the pc
                ctrl.keep_pc_plus_immed = (op == OP_AUIPC);
            end

            // pc relative, return address to rd
            OP_JAL: begin
                fmt                = IMM_UJ;
                ctrl.rs1           = `RV_REG_W'(`RV_REG_ZERO);
                ctrl.funct3        = F3OP_ADD_SUB;
                ctrl.funct7        = 7'b000_0000;
                ctrl.alu_use_immed = 1'b1;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b001;
                ctrl.jump_if       = JUMP_YES;
            end

            // target is the alu result rs1 + immed
            OP_JALR: begin
                fmt                = IMM_I;
                ctrl.funct3        = F3OP_ADD_SUB;
                ctrl.funct7        = 7'b000_0000;
                ctrl.alu_use_immed = 1'b1;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b101;
                ctrl.jump_if       = JUMP_YES;
                ctrl.jump_absolute = 1'b1;
            end

            // condition and compare op come from the branch decoder
            OP_BRANCH: begin
                fmt          = IMM_SB;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b110;
                ctrl.jump_if = br.jump_if;
                ctrl.funct3  = br.funct3;
                ctrl.funct7  = br.funct7;
            end

            // address is rs1 + immed, width stays in funct3
            OP_LOAD: begin
                fmt                = IMM_I;
                ctrl.alu_use_immed = 1'b1;
                ctrl.is_load       = 1'b1;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b101;
            end

            // rs2 carries the store data
            OP_STORE: begin
                fmt                = IMM_S;
                ctrl.alu_use_immed = 1'b1;
                ctrl.is_store      = 1'b1;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b110;
            end

            // i type alu ops
            OP_OP_IMM, OP_IMM_32: begin
                fmt                = IMM_I;
                ctrl.alu_use_immed = 1'b1;
                ctrl.funct7        = 7'b000_0000;
                ctrl.alu_width_32  = (op == OP_IMM_32);
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b101;
            end

            // r type, alu codes pass through
            OP_OP, OP_OP_32: begin
                ctrl.alu_width_32 = (op == OP_OP_32);
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b111;
            end

            // fences, treated as nops
            OP_MISC_MEM: begin
                ctrl.funct7 = 7'b000_0000;
            end

            OP_SYSTEM: begin
                ctrl.funct7 = 7'b000_0000;
                // ecall only, ebreak has inst[20] set
                if (f3 == 3'b000 && !inst[20]) begin
                    ctrl.is_ecall = 1'b1;
                    ctrl.en_rd    = 1'b1;
                    ctrl.rd       = `RV_REG_W'(`RV_REG_A0);
                end
            end

            default: begin
                // unknown opcode stays inactive
                fmt = IMM_NONE;
            end
        endcase
    end

endmodule

//--- design/rv_decode_stage.sv
// decode stage top, joins the decoders and registers the decoded record behind a valid strobe
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_decode_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`RV_ILEN-1:0]          inst,
    input  logic                         in_valid,
    output rv_decode_pkg::decoded_inst_t decoded,
    output logic                         out_valid
);

    import rv_decode_pkg::*;

    // branch condition, from funct3 alone
    branch_ctrl_t        br;
    // format requested by the main decoder
    imm_fmt_e            fmt;
    // control record, immed still zero
    decoded_inst_t       ctrl;
    logic [`RV_XLEN-1:0] immed;
    // record with immediate merged in
    decoded_inst_t       rec_next;

    rv_branch_decode u_branch (
        .funct3 (inst[14:12]),
        .br     (br)
    );

    rv_ctrl_decode u_ctrl (
        .inst (inst),
        .br   (br),
        .fmt  (fmt),
        .ctrl (ctrl)
    );

    rv_imm_gen u_imm (
        .inst  (inst),
        .fmt   (fmt),
        .immed (immed)
    );

    // splice the immediate into the record
    always_comb begin
        rec_next       = ctrl;
        rec_next.immed = immed;
    end

    // one cycle stage register
    // no back-pressure, takes a new inst every valid cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            decoded   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
            // hold last record across bubbles
            if (in_valid) begin
                decoded <= rec_next;
            end
        end
    end

endmodule

//--- sim/rv_decode_stage_tb.sv
// testbench for the decode stage, drives directed and random instructions and checks every record
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_decode_stage_tb;

    import rv_decode_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int DIRECTED_N   = 24;
    localparam int RANDOM_N     = 400;
    // worst case is one bubble per random instruction, plus settle and drain
    localparam int STIM_CYCLES    = RESET_CYCLES + 2 + DIRECTED_N + 2 * RANDOM_N + 4;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 50;

    logic                clk = 1'b0;
    logic                rst;
    logic [`RV_ILEN-1:0] inst;
    logic                in_valid;
    decoded_inst_t       got;
    logic                out_valid;

    // scoreboard, at most one record in flight
    decoded_inst_t       exp_q[$];
    decoded_inst_t       want     = '0;
    // last model record that left the stage, decoded must hold it through bubbles
    decoded_inst_t       held_rec = '0;
    int                  q_len     = 0;
    int                  n_sent    = 0;
    int                  n_checked = 0;
    int                  cyc       = 0;
    logic                rst_d  = 1'b0;
    logic                rst_dd = 1'b0;
    logic                out_active;

    // opcodes the random section picks from
    opcode_e valid_ops [13] = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD,
                                OP_STORE, OP_OP_IMM, OP_IMM_32, OP_OP, OP_OP_32,
                                OP_MISC_MEM, OP_SYSTEM};

    rv_decode_stage dut_i (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .in_valid  (in_valid),
        .decoded   (got),
        .out_valid (out_valid)
    );

    // rest holds inst[31:15] above the rd field
    function automatic logic [31:0] pack_inst(input logic [6:0] op, input logic [2:0] f3,
                                              input logic [21:0] rest);
        return {rest[21:5], f3, rest[4:0], op};
    endfunction

    // expected record straight from the isa field layout
    function automatic decoded_inst_t expected_record(input logic [31:0] ins);
        decoded_inst_t      r;
        logic [2:0]         f3;
        logic signed [63:0] imm_i;
        logic signed [63:0] imm_s;
        logic signed [63:0] imm_b;
        logic signed [63:0] imm_u;
        logic signed [63:0] imm_j;
        f3    = ins[14:12];
        // signed operands sign-extend on assignment
        imm_i = $signed(ins[31:20]);
        imm_s = $signed({ins[31:25], ins[11:7]});
        imm_b = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0});
        imm_u = $signed({ins[31:12], 12'h000});
        imm_j = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0});
        r        = '0;
        r.rs1    = ins[19:15];
        r.rs2    = ins[24:20];
        r.rd     = ins[11:7];
        r.funct3 = f3;
        r.funct7 = ins[31:25];
        case (ins[6:0])
            OP_LUI, OP_AUIPC, OP_JAL: begin
                // x0 + immed through the adder
                r.immed  = (ins[6:0] == OP_JAL) ? imm_j : imm_u;
                r.rs1    = '0;
                r.funct3 = 3'b000;
                r.funct7 = 7'h00;
                r.alu_use_immed      = 1'b1;
                r.en_rd              = 1'b1;
                r.keep_pc_plus_immed = (ins[6:0] == OP_AUIPC);
                r.jump_if            = (ins[6:0] == OP_JAL) ? JUMP_YES : JUMP_NO;
            end
            OP_JALR: begin
                r.immed  = imm_i;
                r.funct3 = 3'b000;
                r.funct7 = 7'h00;
                r.alu_use_immed = 1'b1;
                r.en_rs1        = 1'b1;
                r.en_rd         = 1'b1;
                r.jump_if       = JUMP_YES;
                r.jump_absolute = 1'b1;
            end
            OP_BRANCH: begin
                r.immed  = imm_b;
                r.en_rs1 = 1'b1;
                r.en_rs2 = 1'b1;
                // beq/bne subtract, the rest compare with slt or sltu
                r.funct3 = (f3[2:1] == 2'b10) ? 3'b010 : (f3[2:1] == 2'b11) ? 3'b011 : 3'b000;
                r.funct7 = (f3[2:1] == 2'b00) ? 7'h20 : 7'h00;
                case (f3)
                    3'b000, 3'b101, 3'b111: r.jump_if = JUMP_ALU_EQZ;
                    3'b001, 3'b100, 3'b110: r.jump_if = JUMP_ALU_NEZ;
                    default: r.jump_if = JUMP_NO;
                endcase
                // reserved codes fall back to a plain add
                if (f3[2:1] == 2'b01) begin
                    r.funct3 = 3'b000;
                    r.funct7 = 7'h00;
                end
            end
            OP_LOAD, OP_STORE: begin
                r.immed         = (ins[6:0] == OP_LOAD) ? imm_i : imm_s;
                r.alu_use_immed = 1'b1;
                r.en_rs1        = 1'b1;
                r.en_rs2        = (ins[6:0] == OP_STORE);
                r.en_rd         = (ins[6:0] == OP_LOAD);
                r.is_load       = (ins[6:0] == OP_LOAD);
                r.is_store      = (ins[6:0] == OP_STORE);
            end
            OP_OP_IMM, OP_IMM_32: begin
                r.immed         = imm_i;
                r.alu_use_immed = 1'b1;
                r.funct7        = 7'h00;
                r.alu_width_32  = (ins[6:0] == OP_IMM_32);
                r.en_rs1        = 1'b1;
                r.en_rd         = 1'b1;
            end
            OP_OP, OP_OP_32: begin
                r.alu_width_32 = (ins[6:0] == OP_OP_32);
                {r.en_rs1, r.en_rs2, r.en_rd} = 3'b111;
            end
            OP_MISC_MEM: r.funct7 = 7'h00;
            OP_SYSTEM: begin
                r.funct7 = 7'h00;
                // ecall writes its result to a0
                if (f3 == 3'b000 && ins[20] == 1'b0) begin
                    r.is_ecall = 1'b1;
                    r.en_rd    = 1'b1;
                    r.rd       = `RV_REG_A0;
                end
            end
            default: r.immed = '0;
        endcase
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                   input logic [127:0] act_v);
        $display("Fail %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
        $display("TESTS FAILED");
        $fatal(1, "decoded record mismatch");
    endtask

    task automatic drive_inst(input logic [31:0] ins);
        @(posedge clk);
        inst     <= ins;
        in_valid <= 1'b1;
    endtask

    // bubble, with junk on inst that must not reach decoded
    task automatic drive_idle();
        @(posedge clk);
        inst     <= $urandom;
        in_valid <= 1'b0;
    endtask

    initial begin
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc    <= cyc + 1;
        rst_d  <= rst;
        rst_dd <= rst_d;
    end

    initial begin
        wait (cyc >= TIMEOUT_CYCLES);
        $display("timeout, the decode stage run did not finish in %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

    // pop what left the stage last cycle, push what enters now
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            held_rec = '0;
        end else begin
            if (out_valid) begin
                if (exp_q.size() != 0) begin
                    held_rec = exp_q.pop_front();
                    n_checked++;
                end
            end
            if (in_valid) begin
                exp_q.push_back(expected_record(inst));
                n_sent++;
            end
        end
        q_len = exp_q.size();
        want  = (q_len != 0) ? exp_q[0] : '0;
    end

    assign out_active = (cyc != 0) && out_valid;

    // checks at the falling edge, between updates
    a_reset: assert property (@(negedge clk) (rst_d || rst_dd) |-> got == '0)
        else report_mismatch("decoded", '0, got);
    a_valid: assert property (@(negedge clk) (cyc != 0) |-> out_valid == (q_len != 0))
        else report_mismatch("out_valid", q_len != 0, out_valid);
    a_hold: assert property (@(negedge clk) (cyc != 0 && !out_valid) |-> got == held_rec)
        else report_mismatch("decoded", held_rec, got);
    a_regs: assert property (@(negedge clk)
        out_active |-> {got.rs1, got.rs2, got.rd} == {want.rs1, want.rs2, want.rd})
        else report_mismatch("rs1/rs2/rd", {want.rs1, want.rs2, want.rd},
                             {got.rs1, got.rs2, got.rd});
    a_enables: assert property (@(negedge clk) out_active |->
        {got.en_rs1, got.en_rs2, got.en_rd} == {want.en_rs1, want.en_rs2, want.en_rd})
        else report_mismatch("en_rs1/en_rs2/en_rd", {want.en_rs1, want.en_rs2, want.en_rd},
                             {got.en_rs1, got.en_rs2, got.en_rd});
    a_immed: assert property (@(negedge clk) out_active |-> got.immed == want.immed)
        else report_mismatch("immed", want.immed, got.immed);
    a_alu: assert property (@(negedge clk) out_active |->
        {got.keep_pc_plus_immed, got.alu_use_immed, got.alu_width_32} ==
        {want.keep_pc_plus_immed, want.alu_use_immed, want.alu_width_32})
        else report_mismatch("keep_pc_plus_immed/alu_use_immed/alu_width_32",
            {want.keep_pc_plus_immed, want.alu_use_immed, want.alu_width_32},
            {got.keep_pc_plus_immed, got.alu_use_immed, got.alu_width_32});
    a_funct: assert property (@(negedge clk)
        out_active |-> {got.funct3, got.funct7} == {want.funct3, want.funct7})
        else report_mismatch("funct3/funct7", {want.funct3, want.funct7},
                             {got.funct3, got.funct7});
    a_jump: assert property (@(negedge clk) out_active |->
        {got.jump_if, got.jump_absolute} == {want.jump_if, want.jump_absolute})
        else report_mismatch("jump_if/jump_absolute", {want.jump_if, want.jump_absolute},
                             {got.jump_if, got.jump_absolute});
    a_flags: assert property (@(negedge clk) out_active |->
        {got.is_load, got.is_store, got.is_ecall} == {want.is_load, want.is_store, want.is_ecall})
        else report_mismatch("is_load/is_store/is_ecall",
            {want.is_load, want.is_store, want.is_ecall},
            {got.is_load, got.is_store, got.is_ecall});

    initial begin
        logic [31:0] ins;
        int          k;
        void'($urandom(98556));
        rst      = 1'b1;
        in_valid = 1'b0;
        inst     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        drive_idle();

        // directed, one of each opcode, back to back
        drive_inst(pack_inst(OP_LUI,      3'b101, 22'h3abcd5));
        drive_inst(pack_inst(OP_AUIPC,    3'b010, 22'h100012));
        drive_inst(pack_inst(OP_JAL,      3'b111, 22'h3f07e1));
        drive_inst(pack_inst(OP_JALR,     3'b000, 22'h3fe102));
        drive_inst(pack_inst(OP_LOAD,     3'b011, 22'h2c4823));
        drive_inst(pack_inst(OP_STORE,    3'b010, 22'h0a1c4b));
        drive_inst(pack_inst(OP_OP_IMM,   3'b101, 22'h20080f));
        drive_inst(pack_inst(OP_IMM_32,   3'b000, 22'h3ff3c6));
        drive_inst(pack_inst(OP_OP,       3'b000, 22'h2012a7));
        drive_inst(pack_inst(OP_OP_32,    3'b101, 22'h200d09));
        drive_inst(pack_inst(OP_MISC_MEM, 3'b000, 22'h0ff000));
        // all eight branch codes, reserved ones included
        for (k = 0; k < 8; k++) begin
            drive_inst(pack_inst(OP_BRANCH, 3'(k), 22'h2b5a6d ^ 22'(k)));
        end
        // ecall with a nonzero rd field, ebreak, a csr op
        drive_inst(pack_inst(OP_SYSTEM, 3'b000, 22'h000007));
        drive_inst(pack_inst(OP_SYSTEM, 3'b000, 22'h000400));
        drive_inst(pack_inst(OP_SYSTEM, 3'b001, 22'h30a08b));
        // opcodes outside the table
        drive_inst(pack_inst(7'h7f, 3'b110, 22'h3c3c3c));
        drive_inst(pack_inst(7'h00, 3'b000, 22'h123456));

        // random fields under a valid opcode
        for (k = 0; k < RANDOM_N; k++) begin
            if ($urandom % 4 == 0) begin
                drive_idle();
            end
            ins = pack_inst(valid_ops[$urandom % 13], 3'($urandom), 22'($urandom));
            drive_inst(ins);
        end

        // drain until the last record has left
        drive_idle();
        @(negedge clk);
        while (q_len != 0 || out_valid) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (n_checked == n_sent && n_sent == DIRECTED_N + RANDOM_N) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("record count wrong, %0d sent and %0d checked", n_sent, n_checked);
            $display("TESTS FAILED");
            $fatal(1, "record count mismatch");
        end
    end

endmodule

//--- sim.f
+incdir+design
design/rv_decode_pkg.sv
design/rv_branch_decode.sv
design/rv_imm_gen.sv
design/rv_ctrl_decode.sv
design/rv_decode_stage.sv
sim/rv_decode_stage_tb.sv
